// File: rv_single_cpu.f
+incdir+tb
rtl/rv_isa_pkg.sv
rtl/rv_core_pkg.sv
rtl/rv_inst_mem.sv
rtl/rv_reg_file.sv
rtl/rv_decoder.sv
rtl/rv_alu.sv
rtl/rv_data_mem.sv
rtl/rv_single_cpu.sv
tb/rv_single_cpu_sva.sv
tb/rv_single_cpu_tb.sv

// File: tb/rv_ref_model.svh
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

logic [31:0] m_regs [32];    // Architectural registers of the model
logic [31:0] m_dmem [64];    // Word-indexed model data memory

task automatic model_reset();
    for (int k = 0; k < 32; k++) begin
        m_regs[k] = '0;
    end
    for (int k = 0; k < 64; k++) begin
        m_dmem[k] = '0;
    end
endtask

// Integer result by funct3 with alt selecting sub and sra
function automatic logic [31:0] int_result(logic [2:0] f3, logic alt, logic [31:0] a,
                                           logic [31:0] b);
    case (f3)
        3'b000:  return alt ? a - b : a + b;
        3'b001:  return a << b[4:0];
        3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'b011:  return (a < b) ? 32'd1 : 32'd0;
        3'b100:  return a ^ b;
        3'b101:  return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'b110:  return a | b;
        default: return a & b;
    endcase
endfunction

// Executes one instruction on the model state and gives the expected record
task automatic model_exec(input logic [31:0] pc, input logic [31:0] w, output retire_t exp);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] res;
    logic [31:0] ea;
    logic        wr;
    logic        shift;
    exp       = '0;
    exp.valid = 1'b1;
    exp.pc    = pc;
    a         = m_regs[w[19:15]];
    b         = m_regs[w[24:20]];
    imm_i     = {{20{w[31]}}, w[31:20]};
    imm_s     = {{20{w[31]}}, w[31:25], w[11:7]};
    shift     = (w[13:12] == 2'b01);    // funct3 001 or 101
    wr        = 1'b0;
    res       = '0;
    case (w[6:0])
        7'b0110011: begin
            // Only sub and sra take the alternate funct7
            if (w[31:25] == 7'h00 ||
                (w[31:25] == 7'h20 && (w[14:12] == 3'b000 || w[14:12] == 3'b101))) begin
                wr  = 1'b1;
                res = int_result(w[14:12], w[30], a, b);
            end
        end
        7'b0010011: begin
            if (!shift) begin
                wr  = 1'b1;
                res = int_result(w[14:12], 1'b0, a, imm_i);
            end else if (w[31:25] == 7'h00 || (w[31:25] == 7'h20 && w[14])) begin
                wr  = 1'b1;
                res = int_result(w[14:12], w[30], a, {27'b0, w[24:20]});
            end
        end
        7'b0000011: begin
            if (w[14:12] == 3'b010) begin
                ea  = a + imm_i;
                wr  = 1'b1;
                res = m_dmem[ea[7:2]];
            end
        end
        7'b0100011: begin
            if (w[14:12] == 3'b010) begin
                ea               = a + imm_s;
                exp.mem_write    = 1'b1;
                exp.mem_addr     = ea[7:2];
                exp.mem_data     = b;
                m_dmem[ea[7:2]]  = b;
            end
        end
        default: ;    // No-op
    endcase
    if (wr && w[11:7] != 5'd0) begin
        exp.reg_we        = 1'b1;
        exp.rd            = w[11:7];
        exp.wdata         = res;
        m_regs[w[11:7]]   = res;
    end
endtask

`endif

// File: tb/rv_single_cpu_tb.sv
`timescale 1ns/1ps

module rv_single_cpu_tb import rv_isa_pkg::*, rv_core_pkg::*;;

    localparam int depth    = 64;
    localparam int rand_len = 48;
    localparam int rb_len   = 7;               // Readback of x1 to x7
    localparam int prog_len = rand_len + rb_len;
    localparam int load_len = depth + 1;
    localparam time period  = 100ns;
    localparam time limit   = (prog_len + load_len + 3 + 20) * period;

    logic        CLK;
    logic        RST;
    logic        prog_we;
    logic [5:0]  prog_addr;
    logic [31:0] prog_data;
    logic        run;
    retire_t     retire;

    logic [31:0] prog [depth];
    retire_t     exp;

    `include "rv_ref_model.svh"

    rv_single_cpu #(
        .IMEM_DEPTH(depth),
        .DMEM_DEPTH(depth)
    ) uut (
        .CLK       (CLK),
        .RST       (RST),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .run       (run),
        .retire    (retire)
    );

    always #(period / 2) CLK = ~CLK;

    function automatic logic [31:0] enc(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3, logic [4:0] rd, logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    // Fields with no meaning for this instruction cleared
    function automatic retire_t significant(retire_t r);
        if (!r.reg_we) begin
            r.rd    = '0;
            r.wdata = '0;
        end
        if (!r.mem_write) begin
            r.mem_addr = '0;
            r.mem_data = '0;
        end
        return r;
    endfunction

    task automatic stop_failed();
        $display("Simulation failed");
        $fatal(1, "stopping at first mismatch");
    endtask

    task automatic check_retire(input retire_t got, input retire_t want, input string what);
        if (got !== want) begin
            $display("error %0t: %s retire got %h expected %h", $time, what, got, want);
            stop_failed();
        end
    endtask

    task automatic check_word(input logic [31:0] got, input logic [31:0] want,
                              input string what);
        if (got !== want) begin
            $display("error %0t: %s got %h expected %h", $time, what, got, want);
            stop_failed();
        end
    endtask

    function automatic logic [31:0] random_inst();
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [11:0] imm;
        int          kind;
        rd   = 5'($urandom % 8);    // Small pool for dependencies
        rs1  = 5'($urandom % 8);
        rs2  = 5'($urandom % 8);
        f3   = 3'($urandom);
        imm  = 12'($urandom);
        kind = $urandom % 20;
        if ($urandom % 2) begin
            imm = 12'(($urandom % 16) * 4);    // Low word indices, to hit stores
            if (kind >= 12 && kind < 18) begin
                rs1 = 5'd0;
            end
        end
        if (kind < 6) begin
            if ((f3 == 3'b000 || f3 == 3'b101) && ($urandom % 2)) begin
                return enc(funct7_alt, rs2, rs1, f3, rd, op_reg);
            end
            return enc(funct7_base, rs2, rs1, f3, rd, op_reg);
        end else if (kind < 12) begin
            if (f3 == 3'b001) begin
                return enc(funct7_base, imm[4:0], rs1, f3, rd, op_imm);
            end else if (f3 == 3'b101) begin
                return enc(($urandom % 2) ? funct7_alt : funct7_base, imm[4:0], rs1, f3, rd,
                           op_imm);
            end
            return enc(imm[11:5], imm[4:0], rs1, f3, rd, op_imm);
        end else if (kind < 15) begin
            return enc(imm[11:5], imm[4:0], rs1, f3_word, rd, op_load);
        end else if (kind < 18) begin
            return enc(imm[11:5], rs2, rs1, f3_word, imm[4:0], op_store);
        end else if (kind == 18) begin
            return enc(imm[11:5], imm[4:0], rs1, 3'b000, 5'd0, op_imm);    // Write to x0
        end
        return {$urandom} | 32'h7f;    // Unknown opcode 1111111
    endfunction

    initial begin
        #(limit);
        $display("Run timed out after %0t without finishing the program", limit);
        $display("Simulation failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        void'($urandom(32'h9c5ba6a1));
        CLK       = 1'b0;
        RST       = 1'b1;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        run       = 1'b0;
        model_reset();
        for (int k = 0; k < depth; k++) begin
            if (k < rand_len) begin
                prog[k] = random_inst();
            end else if (k < prog_len) begin
                prog[k] = enc(7'd0, 5'd0, 5'(k - rand_len + 1), 3'b000, 5'(k - rand_len + 1),
                              op_imm);    // addi xk, xk, 0
            end else begin
                prog[k] = 32'h0000_0013;    // addi x0, x0, 0
            end
        end
        repeat (3) @(posedge CLK);
        RST <= 1'b0;
        for (int k = 0; k < depth; k++) begin
            @(posedge CLK);
            prog_we   <= 1'b1;
            prog_addr <= 6'(k);
            prog_data <= prog[k];
            @(negedge CLK);
            check_retire(significant(retire), '0, "idle");
        end
        @(posedge CLK);
        prog_we <= 1'b0;
        run     <= 1'b1;
        for (int n = 0; n < prog_len; n++) begin
            @(negedge CLK);
            model_exec(32'(n * 4), prog[n], exp);
            check_retire(significant(retire), exp, "execute");
            if (n >= rand_len) begin
                check_word(retire.wdata, m_regs[n - rand_len + 1], "register readback");
            end
        end
        @(posedge CLK);
        run <= 1'b0;
        @(negedge CLK);
        check_word(32'(retire.valid), 32'd0, "valid after stop");
        $display("Simulation passed");
        $finish;
    end

endmodule

// File: tb/rv_single_cpu_sva.sv
`timescale 1ns/1ps

module rv_single_cpu_sva import rv_core_pkg::*; (
    input logic    CLK,
    input logic    RST,
    input logic    run,
    input retire_t retire
);

    no_x0_write: assert property (@(posedge CLK) disable iff (RST)
        !(retire.reg_we && retire.rd == 5'd0))
        else $error("register write reported for x0");

    no_dual_write: assert property (@(posedge CLK) disable iff (RST)
        !(retire.reg_we && retire.mem_write))
        else $error("register and memory write in one instruction");

    pc_step: assert property (@(posedge CLK) disable iff (RST)
        run |=> retire.pc == $past(retire.pc) + 32'd4)
        else $error("program counter did not advance by 4");

    idle_after_reset: assert property (@(posedge CLK)
        ($past(RST) && !RST) |-> !retire.valid)
        else $error("retire valid right after reset");

endmodule

bind rv_single_cpu rv_single_cpu_sva u_sva (
    .CLK    (CLK),
    .RST    (RST),
    .run    (run),
    .retire (retire)
);

// File: rtl/rv_single_cpu.sv
`timescale 1ns/1ps

module rv_single_cpu import rv_isa_pkg::*, rv_core_pkg::*; #(
    parameter int IMEM_DEPTH = 64,
    parameter int DMEM_DEPTH = 64
) (
    input  logic                          CLK,
    input  logic                          RST,
    input  logic                          prog_we,
    input  logic [$clog2(IMEM_DEPTH)-1:0] prog_addr,
    input  logic [31:0]                   prog_data,
    input  logic                          run,
    output retire_t                       retire
);

    localparam int imem_aw = $clog2(IMEM_DEPTH);
    localparam int dmem_aw = $clog2(DMEM_DEPTH);

    logic [31:0]        pc;
    inst_t              inst;
    ctrl_t              ctrl;
    logic [31:0]        imm;
    logic [31:0]        rs1_data;
    logic [31:0]        rs2_data;
    logic [31:0]        alu_b;
    logic [31:0]        alu_y;
    logic [dmem_aw-1:0] dmem_addr;
    logic [31:0]        dmem_rd;
    logic [31:0]        wb_data;
    logic               commit;    // Instruction takes effect this edge
    logic               reg_we;
    logic               mem_we;

    // One instruction per edge while run is high
    always_ff @(posedge CLK) begin
        if (RST) begin
            pc <= '0;
        end else if (run) begin
            pc <= pc + 32'd4;
        end
    end

    rv_inst_mem #(
        .IMEM_DEPTH(IMEM_DEPTH)
    ) u_inst_mem (
        .CLK       (CLK),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .addr      (pc[imem_aw+1:2]),
        .inst      (inst)
    );

    rv_decoder u_decoder (
        .inst (inst),
        .ctrl (ctrl),
        .imm  (imm)
    );

    rv_reg_file u_reg_file (
        .CLK (CLK),
        .RST (RST),
        .rs1 (ctrl.rs1),
        .rs2 (ctrl.rs2),
        .rd  (ctrl.rd),
        .we  (reg_we),
        .wd  (wb_data),
        .rd1 (rs1_data),
        .rd2 (rs2_data)
    );

    assign alu_b = ctrl.use_imm ? imm : rs2_data;

    rv_alu u_alu (
        .op (ctrl.alu_op),
        .a  (rs1_data),
        .b  (alu_b),
        .y  (alu_y)
    );

    assign dmem_addr = alu_y[dmem_aw+1:2];    // Low two bits ignored

    rv_data_mem #(
        .DMEM_DEPTH(DMEM_DEPTH)
    ) u_data_mem (
        .CLK  (CLK),
        .RST  (RST),
        .we   (mem_we),
        .addr (dmem_addr),
        .wd   (rs2_data),
        .rd   (dmem_rd)
    );

    // Unknown encodings commit nothing
    assign commit  = run && ctrl.valid_op;
    assign reg_we  = commit && ctrl.reg_we;
    assign mem_we  = commit && ctrl.mem_write;
    assign wb_data = ctrl.mem_read ? dmem_rd : alu_y;

    always_comb begin
        retire.valid     = run;
        retire.pc        = pc;
        retire.reg_we    = reg_we;
        retire.rd        = ctrl.rd;
        retire.wdata     = wb_data;
        retire.mem_write = mem_we;
        retire.mem_addr  = mem_addr_w'(dmem_addr);
        retire.mem_data  = rs2_data;    // Store data is rs2
    end

endmodule

// File: rtl/rv_data_mem.sv
`timescale 1ns/1ps

module rv_data_mem #(
    parameter int DMEM_DEPTH = 64
) (
    input  logic                          CLK,
    input  logic                          RST,
    input  logic                          we,
    input  logic [$clog2(DMEM_DEPTH)-1:0] addr,
    input  logic [31:0]                   wd,
    output logic [31:0]                   rd
);

    logic [31:0] mem [DMEM_DEPTH];

    always_ff @(posedge CLK) begin
        if (RST) begin
            for (int i = 0; i < DMEM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[addr] <= wd;
        end
    end

    // Word index already wrapped by its width
    assign rd = mem[addr];

endmodule

// File: rtl/rv_alu.sv
`timescale 1ns/1ps

module rv_alu import rv_core_pkg::*; (
    input  alu_op_e     op,
    input  logic [31:0] a,
    input  logic [31:0] b,
    output logic [31:0] y
);

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;

    assign shamt = b[4:0];    // Only low five bits shift
    assign lt_s  = $signed(a) < $signed(b);
    assign lt_u  = a < b;

    always_comb begin
        case (op)
            alu_add:  y = a + b;
            alu_sub:  y = a - b;
            alu_sll:  y = a << shamt;
            alu_slt:  y = {31'b0, lt_s};
            alu_sltu: y = {31'b0, lt_u};
            alu_xor:  y = a ^ b;
            alu_srl:  y = a >> shamt;
            alu_sra:  y = $unsigned($signed(a) >>> shamt);
            alu_or:   y = a | b;
            alu_and:  y = a & b;
            default:  y = '0;
        endcase
    end

endmodule

// File: rtl/rv_decoder.sv
`timescale 1ns/1ps

module rv_decoder import rv_isa_pkg::*, rv_core_pkg::*; (
    input  inst_t       inst,
    output ctrl_t       ctrl,
    output logic [31:0] imm
);

    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_sh;
    logic        alt;       // funct7 bit 30 pattern
    logic        f7_ok;     // Legal funct7 for this funct3
    alu_op_e     op_sel;

    // Sign taken from instruction bit 31
    assign imm_i  = {{20{inst.funct7[6]}}, inst.funct7, inst.rs2};
    assign imm_s  = {{20{inst.funct7[6]}}, inst.funct7, inst.rd};
    assign imm_sh = {27'b0, inst.rs2};    // shamt only

    assign alt   = (inst.funct7 == funct7_alt);
    assign f7_ok = (inst.funct7 == funct7_base) ||
                   (alt && (inst.funct3 == f3_add || inst.funct3 == f3_srl));

    // Operation from funct3, alt picks sub and sra
    always_comb begin
        case (inst.funct3)
            f3_add:  op_sel = alt ? alu_sub : alu_add;
            f3_sll:  op_sel = alu_sll;
            f3_slt:  op_sel = alu_slt;
            f3_sltu: op_sel = alu_sltu;
            f3_xor:  op_sel = alu_xor;
            f3_srl:  op_sel = alt ? alu_sra : alu_srl;
            f3_or:   op_sel = alu_or;
            default: op_sel = alu_and;
        endcase
    end

    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = alu_add;
        ctrl.rd     = inst.rd;
        ctrl.rs1    = inst.rs1;
        ctrl.rs2    = inst.rs2;
        imm         = '0;
        case (inst.opcode)
            op_reg: begin
                ctrl.alu_op   = op_sel;
                ctrl.reg_we   = f7_ok;
                ctrl.valid_op = f7_ok;
            end
            op_imm: begin
                ctrl.use_imm = 1'b1;
                if (inst.funct3 == f3_sll || inst.funct3 == f3_srl) begin
                    ctrl.alu_op   = op_sel;
                    ctrl.reg_we   = f7_ok;
                    ctrl.valid_op = f7_ok;
                    imm           = imm_sh;
                end else begin
                    // funct7 is immediate data here, so addi never turns into sub
                    ctrl.alu_op   = (inst.funct3 == f3_add) ? alu_add : op_sel;
                    ctrl.reg_we   = 1'b1;
                    ctrl.valid_op = 1'b1;
                    imm           = imm_i;
                end
            end
            op_load: begin
                if (inst.funct3 == f3_word) begin
                    ctrl.use_imm  = 1'b1;
                    ctrl.mem_read = 1'b1;
                    ctrl.reg_we   = 1'b1;
                    ctrl.valid_op = 1'b1;
                    imm           = imm_i;
                end
            end
            op_store: begin
                if (inst.funct3 == f3_word) begin
                    ctrl.use_imm   = 1'b1;
                    ctrl.mem_write = 1'b1;
                    ctrl.valid_op  = 1'b1;
                    imm            = imm_s;
                end
            end
            default: begin
                ctrl.valid_op = 1'b0;    // Retires as a no-op
            end
        endcase
        ctrl.reg_we = ctrl.reg_we && (inst.rd != 5'd0);
    end

endmodule

// File: rtl/rv_reg_file.sv
`timescale 1ns/1ps

module rv_reg_file (
    input  logic        CLK,
    input  logic        RST,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    input  logic [4:0]  rd,
    input  logic        we,
    input  logic [31:0] wd,
    output logic [31:0] rd1,
    output logic [31:0] rd2
);

    logic [31:0] regs [32];

    always_ff @(posedge CLK) begin
        if (RST) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != 5'd0) begin    // x0 never written
            regs[rd] <= wd;
        end
    end

    // Read ports, no bypass of the same-cycle write
    assign rd1 = regs[rs1];
    assign rd2 = regs[rs2];

endmodule

// File: rtl/rv_inst_mem.sv
`timescale 1ns/1ps

module rv_inst_mem import rv_isa_pkg::*; #(
    parameter int IMEM_DEPTH = 64
) (
    input  logic                          CLK,
    input  logic                          prog_we,
    input  logic [$clog2(IMEM_DEPTH)-1:0] prog_addr,
    input  logic [31:0]                   prog_data,
    input  logic [$clog2(IMEM_DEPTH)-1:0] addr,
    output inst_t                         inst
);

    logic [31:0] mem [IMEM_DEPTH];    // Program words, loaded from outside

    // Loading port, used only while the core is stopped
    always_ff @(posedge CLK) begin
        if (prog_we) begin
            mem[prog_addr] <= prog_data;
        end
    end

    // Word index narrower than the PC, so fetch wraps to the depth
    assign inst = mem[addr];

endmodule

// File: rtl/rv_core_pkg.sv
package rv_core_pkg;

    // Width of the data memory word index in the retire record
    localparam int mem_addr_w = 6;

    // Operations of the ALU
    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_sll  = 4'd2,
        alu_slt  = 4'd3,
        alu_sltu = 4'd4,
        alu_xor  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_or   = 4'd8,
        alu_and  = 4'd9
    } alu_op_e;

    // Decoded control for one instruction
    typedef struct packed {
        alu_op_e    alu_op;
        logic       use_imm;      // Operand b is the immediate
        logic       reg_we;       // Already low for rd of zero
        logic       mem_read;
        logic       mem_write;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic       valid_op;     // Known instruction
    } ctrl_t;

    // What one executed instruction did
    typedef struct packed {
        logic                  valid;
        logic [31:0]           pc;
        logic                  reg_we;
        logic [4:0]            rd;
        logic [31:0]           wdata;       // Register write value
        logic                  mem_write;
        logic [mem_addr_w-1:0] mem_addr;    // Word index
        logic [31:0]           mem_data;
    } retire_t;

endpackage

// File: rtl/rv_isa_pkg.sv
package rv_isa_pkg;

    // Major opcodes of the supported instruction classes
    typedef enum logic [6:0] {
        op_load  = 7'b0000011,
        op_imm   = 7'b0010011,
        op_store = 7'b0100011,
        op_reg   = 7'b0110011
    } opcode_e;

    // funct3 codes of the integer operations
    typedef enum logic [2:0] {
        f3_add  = 3'b000,    // Also sub with funct7 alt
        f3_sll  = 3'b001,
        f3_slt  = 3'b010,
        f3_sltu = 3'b011,
        f3_xor  = 3'b100,
        f3_srl  = 3'b101,    // Also sra with funct7 alt
        f3_or   = 3'b110,
        f3_and  = 3'b111
    } funct3_e;

    // Word width code for lw and sw, shares its value with f3_slt
    localparam logic [2:0] f3_word = 3'b010;

    // funct7 patterns
    localparam logic [6:0] funct7_base = 7'b0000000;
    localparam logic [6:0] funct7_alt  = 7'b0100000;    // Selects sub and sra

    // Field split in RISC-V bit order; I and S immediates are read from
    // these fields by the decoder
    typedef struct packed {
        logic [6:0] funct7;    // [31:25]
        logic [4:0] rs2;       // [24:20]
        logic [4:0] rs1;       // [19:15]
        funct3_e    funct3;    // [14:12]
        logic [4:0] rd;        // [11:7]
        opcode_e    opcode;    // [6:0]
    } inst_t;

endpackage
